//--- include/mapper_config.svh
`ifndef MAPPER_CONFIG_SVH
`define MAPPER_CONFIG_SVH

// number of address regions decoded from the register file
`define MAPPER_REGIONS 8

// register file depth in bytes
`define MAPPER_MMR_DEPTH 32

// byte latch towards the sound CPU
`define MAPPER_SND_LATCH 3

// region registers start here, two bytes per region
`define MAPPER_REGION_BASE 16

// offset of the control byte inside a region pair
// bits 3..2 wait code, bits 1..0 size code
`define MAPPER_CTL_OFS 0

// offset of the base byte inside a region pair
`define MAPPER_BASE_OFS 1

`endif

//--- src/mapper_pkg.sv
`default_nettype none

`include "mapper_config.svh"

package mapper_pkg;

    // span of one region taken from control bits 1..0
    typedef enum logic [1:0] {
        size_64k  = 2'd0,
        size_128k = 2'd1,
        size_512k = 2'd2,
        size_2m   = 2'd3
    } region_size_t;

    // wait-state code taken from control bits 3..2
    typedef logic [1:0] dtack_t;

    // one-hot region select that is all zero when no region matches
    typedef logic [`MAPPER_REGIONS-1:0] region_sel_t;

    // byte address inside the register file
    typedef logic [$clog2(`MAPPER_MMR_DEPTH)-1:0] mmr_index_t;

    // one byte per region for both the base and the control arrays
    typedef logic [`MAPPER_REGIONS-1:0][7:0] region_bytes_t;

endpackage

`default_nettype wire

//--- src/mapper_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "mapper_config.svh"

module mapper_regs import mapper_pkg::*; (
    input  wire           clk,
    input  wire           rst,
    input  wire           cpu_asn,
    input  wire [1:0]     cpu_dswn,
    input  mmr_index_t    cpu_index,
    input  wire [7:0]     cpu_data,
    input  wire           region_hit,
    input  mmr_index_t    mcu_index,
    input  wire [7:0]     mcu_data,
    input  wire           mcu_wr,
    input  wire           sndmap_rd,
    output region_bytes_t region_base,
    output region_bytes_t region_ctl,
    output wire [7:0]     sndmap_dout,
    output logic          sndmap_obf
);

    logic [7:0] mmr [`MAPPER_MMR_DEPTH];

    // high while the CPU still owns the register file
    logic       cpu_sel;

    mmr_index_t wr_index;
    logic [7:0] wr_data;
    logic       wr_en;
    logic       cpu_wr;
    logic       snd_wr;

    // CPU writes only the low byte, and only outside every mapped region
    assign cpu_wr = ~cpu_asn & ~cpu_dswn[0] & ~region_hit;

    // write source follows the current owner
    assign wr_index = cpu_sel ? cpu_index : mcu_index;
    assign wr_data  = cpu_sel ? cpu_data : mcu_data;
    assign wr_en    = cpu_sel ? cpu_wr : mcu_wr;

    assign snd_wr = wr_en && (wr_index == mmr_index_t'(`MAPPER_SND_LATCH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MAPPER_MMR_DEPTH; i++) begin
                mmr[i] <= '0;
            end
            cpu_sel    <= 1'b1;
            sndmap_obf <= 1'b0;
        end else begin
            // first MCU write takes over until the next reset
            if (mcu_wr) begin
                cpu_sel <= 1'b0;
            end
            if (wr_en) begin
                mmr[wr_index] <= wr_data;
            end
            // sound CPU read clears the flag, even against a new write
            if (sndmap_rd) begin
                sndmap_obf <= 1'b0;
            end else if (snd_wr) begin
                sndmap_obf <= 1'b1;
            end
        end
    end

    assign sndmap_dout = mmr[`MAPPER_SND_LATCH];

    // region pairs sit at the top half of the map
    for (genvar r = 0; r < `MAPPER_REGIONS; r++) begin : g_region
        assign region_ctl[r]  = mmr[`MAPPER_REGION_BASE + 2*r + `MAPPER_CTL_OFS];
        assign region_base[r] = mmr[`MAPPER_REGION_BASE + 2*r + `MAPPER_BASE_OFS];
    end

    // the buffer-full flag only rises after a latch write
    a_obf_source: assert property (@(posedge clk) disable iff (rst)
        $rose(sndmap_obf) |-> $past(snd_wr));

    // MCU ownership is sticky
    a_owner_sticky: assert property (@(posedge clk) disable iff (rst)
        !cpu_sel |=> !cpu_sel);

endmodule

`default_nettype wire

//--- src/region_decode.sv
`timescale 1ns/1ps
`default_nettype none

`include "mapper_config.svh"

module region_decode import mapper_pkg::*; (
    input  wire [23:1]    addr,
    input  wire [2:0]     cpu_fc,
    input  region_bytes_t region_base,
    input  region_bytes_t region_ctl,
    output region_sel_t   active,
    output dtack_t        dtack_cyc
);

    region_sel_t  hit;
    region_size_t size;

    // raw match of every region with overlaps allowed
    always_comb begin
        hit  = '0;
        size = size_64k;
        for (int r = 0; r < `MAPPER_REGIONS; r++) begin
            size = region_size_t'(region_ctl[r][1:0]);
            case (size)
                // 64 KB compares the full base byte
                size_64k:  hit[r] = addr[23:16] == region_base[r];
                // 128 KB
                size_128k: hit[r] = addr[23:17] == region_base[r][7:1];
                // 512 KB
                size_512k: hit[r] = addr[23:19] == region_base[r][7:3];
                // 2 MB compares only three base bits
                size_2m:   hit[r] = addr[23:21] == region_base[r][7:5];
                default:   hit[r] = 1'b0;
            endcase
        end
    end

    always_comb begin
        // lowest numbered region wins
        active = hit & (~hit + region_sel_t'(1));
        // interrupt acknowledge cycles decode nothing
        if (&cpu_fc) begin
            active = '0;
        end
    end

    // wait code of the selected region, zero without a hit
    always_comb begin
        dtack_cyc = '0;
        for (int r = 0; r < `MAPPER_REGIONS; r++) begin
            if (active[r]) begin
                dtack_cyc = region_ctl[r][3:2];
            end
        end
    end

    always_comb begin
        a_onehot: assert ($onehot0(active))
        else $error("region select is not one-hot: %b", active);
    end

endmodule

`default_nettype wire

//--- src/vint_irq.sv
`timescale 1ns/1ps
`default_nettype none

module vint_irq (
    input  wire  clk,
    input  wire  rst,
    input  wire  vint,
    input  wire  int_ack,
    output logic irqn
);

    // vint from the previous clock
    logic last_vint;
    logic vint_rise;

    assign vint_rise = vint & ~last_vint;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            last_vint <= 1'b0;
            irqn      <= 1'b1;
        end else begin
            last_vint <= vint;
            // acknowledge beats a fresh edge
            if (int_ack) begin
                irqn <= 1'b1;
            end else if (vint_rise) begin
                irqn <= 1'b0;
            end
        end
    end

    // request is always released after an acknowledge
    a_ack_clears: assert property (@(posedge clk) disable iff (rst)
        int_ack |=> irqn);

endmodule

`default_nettype wire

//--- src/bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter (
    input  wire clk,
    input  wire rst,
    input  wire cen,
    input  wire dev_br,
    input  wire cpu_bgn,
    input  wire cpu_asn,
    input  wire cpu_dtackn,
    output wire cpu_brn,
    output wire cpu_bgackn
);

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_req  = 2'd1,
        st_own  = 2'd2
    } arb_state_t;

    arb_state_t state;

    // CPU has granted and finished its own cycle
    logic bus_free;

    assign bus_free = ~cpu_bgn & cpu_asn & cpu_dtackn;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else if (cen) begin
            case (state)
                st_idle: if (dev_br) state <= st_req;
                // wait for grant plus an idle bus
                st_req:  if (bus_free) state <= st_own;
                // device keeps the bus while dev_br stays high
                st_own:  if (!dev_br) state <= st_idle;
                default: state <= st_idle;
            endcase
        end
    end

    // BR only while requesting, BGACK releases it
    assign cpu_brn    = state != st_req;
    assign cpu_bgackn = state != st_own;

    a_no_overlap: assert property (@(posedge clk) disable iff (rst)
        !(!cpu_brn && !cpu_bgackn));

endmodule

`default_nettype wire

//--- src/mapper_top.sv
`timescale 1ns/1ps
`default_nettype none

module mapper_top import mapper_pkg::*; (
    input  wire         clk,
    input  wire         rst,
    input  wire         cpu_cen,
    input  wire         vint,
    // 68000 side
    input  wire [23:1]  addr,
    input  wire [15:0]  cpu_dout,
    input  wire [1:0]   cpu_dswn,
    input  wire         cpu_asn,
    input  wire [2:0]   cpu_fc,
    input  wire         cpu_dtackn,
    input  wire         cpu_bgn,
    output region_sel_t active,
    output dtack_t      dtack_cyc,
    output wire [2:0]   cpu_ipln,
    output wire         cpu_vpan,
    output wire         cpu_brn,
    output wire         cpu_bgackn,
    // MCU side
    input  mmr_index_t  mcu_addr,
    input  wire [7:0]   mcu_dout,
    input  wire         mcu_wr,
    // sound CPU side
    input  wire         sndmap_rd,
    output wire [7:0]   sndmap_dout,
    output wire         sndmap_obf,
    // external bus master
    input  wire         dev_br
);

    region_bytes_t region_base;
    region_bytes_t region_ctl;
    logic          int_ack;
    logic          irqn;

    // autovector acknowledge is FC all ones with AS asserted
    assign int_ack  = (&cpu_fc) & ~cpu_asn;
    assign cpu_vpan = ~int_ack;

    // only level 4 is ever requested
    assign cpu_ipln = {irqn, 2'b11};

    mapper_regs u_regs (
        .clk         (clk),
        .rst         (rst),
        .cpu_asn     (cpu_asn),
        .cpu_dswn    (cpu_dswn),
        .cpu_index   (addr[5:1]),
        .cpu_data    (cpu_dout[7:0]),
        .region_hit  (|active),
        .mcu_index   (mcu_addr),
        .mcu_data    (mcu_dout),
        .mcu_wr      (mcu_wr),
        .sndmap_rd   (sndmap_rd),
        .region_base (region_base),
        .region_ctl  (region_ctl),
        .sndmap_dout (sndmap_dout),
        .sndmap_obf  (sndmap_obf)
    );

    region_decode u_decode (
        .addr        (addr),
        .cpu_fc      (cpu_fc),
        .region_base (region_base),
        .region_ctl  (region_ctl),
        .active      (active),
        .dtack_cyc   (dtack_cyc)
    );

    vint_irq u_irq (
        .clk     (clk),
        .rst     (rst),
        .vint    (vint),
        .int_ack (int_ack),
        .irqn    (irqn)
    );

    bus_arbiter u_arb (
        .clk        (clk),
        .rst        (rst),
        .cen        (cpu_cen),
        .dev_br     (dev_br),
        .cpu_bgn    (cpu_bgn),
        .cpu_asn    (cpu_asn),
        .cpu_dtackn (cpu_dtackn),
        .cpu_brn    (cpu_brn),
        .cpu_bgackn (cpu_bgackn)
    );

endmodule

`default_nettype wire

//--- dv/mapper_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mapper_config.svh"

module mapper_tb import mapper_pkg::*; ();

    logic          clk = 1'b0;
    logic          rst;
    logic          cpu_cen = 1'b1;
    logic          vint;
    logic [23:1]   addr;
    logic [15:0]   cpu_dout;
    logic [1:0]    cpu_dswn;
    logic          cpu_asn;
    logic [2:0]    cpu_fc;
    logic          cpu_dtackn;
    logic          cpu_bgn;
    region_sel_t   active;
    dtack_t        dtack_cyc;
    logic [2:0]    cpu_ipln;
    logic          cpu_vpan;
    logic          cpu_brn;
    logic          cpu_bgackn;
    mmr_index_t    mcu_addr;
    logic [7:0]    mcu_dout;
    logic          mcu_wr;
    logic          sndmap_rd;
    logic [7:0]    sndmap_dout;
    logic          sndmap_obf;
    logic          dev_br;

    // reference state that the checking process keeps
    logic [7:0]    model [`MAPPER_MMR_DEPTH];
    logic          model_cpu_owner;
    logic          model_obf;
    logic          model_irqn;
    logic          model_last_vint;

    integer        seed;
    string         test_name;

    // region layout with overlaps at pages 0x20 and 0x41
    localparam logic [7:0] ctl_tab [`MAPPER_REGIONS] =
        '{8'h04, 8'h09, 8'h0E, 8'h07, 8'h08, 8'h0F, 8'h00, 8'h09};
    localparam logic [7:0] base_tab [`MAPPER_REGIONS] =
        '{8'h10, 8'h20, 8'h40, 8'h80, 8'h41, 8'h20, 8'h00, 8'hC0};

    mapper_top u_mapper_top (.*);

    always #5 clk = ~clk;

    // enable toggles so the arbiter sees idle cycles
    always @(negedge clk) cpu_cen = ~cpu_cen;

    // expected {wait code, region select} from the model registers
    function automatic logic [9:0] ref_decode(input logic [23:1] a, input logic [2:0] fc);
        region_sel_t sel;
        dtack_t      code;
        logic [7:0]  ctl;
        logic [7:0]  base;
        logic        hit;
        sel  = '0;
        code = '0;
        // walk downwards so the lowest hit stays
        for (int r = `MAPPER_REGIONS - 1; r >= 0; r--) begin
            ctl  = model[`MAPPER_REGION_BASE + 2 * r];
            base = model[`MAPPER_REGION_BASE + 2 * r + 1];
            case (ctl[1:0])
                2'd0:    hit = a[23:16] == base;
                2'd1:    hit = a[23:17] == base[7:1];
                2'd2:    hit = a[23:19] == base[7:3];
                default: hit = a[23:21] == base[7:5];
            endcase
            if (hit) begin
                sel  = region_sel_t'(1) << r;
                code = ctl[3:2];
            end
        end
        // acknowledge cycles select nothing
        if (fc == 3'b111) begin
            sel  = '0;
            code = '0;
        end
        return {code, sel};
    endfunction

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Testbench failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_sel(input string what, input region_sel_t exp, input region_sel_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_dtack(input string what, input dtack_t exp, input dtack_t act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s %s: expected %0d, actual %0d", test_name, what, exp, act));
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s %s: expected %b, actual %b", test_name, what, exp, act));
        end
    endtask

    task automatic check_byte(input string what, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            stop_run($sformatf("FAIL %s %s: expected %h, actual %h", test_name, what, exp, act));
        end
    endtask

    // flags that the directed steps wait on
    function automatic logic level_of(input string name);
        if (name == "sndmap_obf") return sndmap_obf;
        if (name == "ipl_level4") return cpu_ipln == 3'b011;
        if (name == "ipl_idle") return cpu_ipln == 3'b111;
        if (name == "cpu_brn") return cpu_brn;
        if (name == "cpu_bgackn") return cpu_bgackn;
        return 1'bx;
    endfunction

    // poll on falling edges and give up after limit cycles
    task automatic wait_level(input string name, input logic level, input int limit);
        int n;
        n = 0;
        while (level_of(name) !== level) begin
            if (n == limit) begin
                stop_run($sformatf("timeout in %s: %s did not reach %b within %0d cycles",
                    test_name, name, level, limit));
            end
            @(negedge clk);
            n++;
        end
    endtask

    // bus stays requested and not yet acknowledged for n cycles
    task automatic hold_request(input int n);
        repeat (n) begin
            @(negedge clk);
            check_bit("request held", 1'b0, cpu_brn);
            check_bit("no early bgack", 1'b1, cpu_bgackn);
        end
    endtask

    // low-byte write on a page that no region covers
    task automatic cpu_write(input int index, input logic [7:0] data);
        @(negedge clk);
        addr     = {8'hFE, 10'h000, mmr_index_t'(index)};
        cpu_dout = {8'h00, data};
        cpu_fc   = 3'b101;
        cpu_asn  = 1'b0;
        cpu_dswn = 2'b10;
        @(negedge clk);
        cpu_dswn = 2'b11;
    endtask

    task automatic mcu_write(input int index, input logic [7:0] data);
        @(negedge clk);
        mcu_addr = mmr_index_t'(index);
        mcu_dout = data;
        mcu_wr   = 1'b1;
        @(negedge clk);
        mcu_wr   = 1'b0;
    endtask

    // compare every cycle, then advance the model
    always @(posedge clk) begin
        logic [9:0] exp_dec;
        logic       wr;
        mmr_index_t wr_index;
        logic [7:0] wr_data;
        if (rst) begin
            for (int i = 0; i < `MAPPER_MMR_DEPTH; i++) begin
                model[i] = '0;
            end
            model_cpu_owner = 1'b1;
            model_obf       = 1'b0;
            model_irqn      = 1'b1;
            model_last_vint = 1'b0;
        end else begin
            exp_dec = ref_decode(addr, cpu_fc);
            check_sel("region select", exp_dec[7:0], active);
            check_dtack("wait code", exp_dec[9:8], dtack_cyc);
            check_bit("vpa", ~(&cpu_fc & ~cpu_asn), cpu_vpan);
            check_bit("sound flag", model_obf, sndmap_obf);
            check_byte("sound data", model[`MAPPER_SND_LATCH], sndmap_dout);
            check_bit("level 4 request", model_irqn, cpu_ipln[2]);
            check_bit("ipl low bits", 1'b1, &cpu_ipln[1:0]);
            check_bit("br and bgack apart", 1'b1, cpu_brn | cpu_bgackn);
            // CPU writes only outside all regions, until the MCU takes over
            if (model_cpu_owner) begin
                wr       = ~cpu_asn & ~cpu_dswn[0] & (exp_dec[7:0] == '0);
                wr_index = addr[5:1];
                wr_data  = cpu_dout[7:0];
            end else begin
                wr       = mcu_wr;
                wr_index = mcu_addr;
                wr_data  = mcu_dout;
            end
            if (wr) begin
                model[wr_index] = wr_data;
            end
            if (mcu_wr) begin
                model_cpu_owner = 1'b0;
            end
            // read beats a new latch write
            if (sndmap_rd) begin
                model_obf = 1'b0;
            end else if (wr && wr_index == mmr_index_t'(`MAPPER_SND_LATCH)) begin
                model_obf = 1'b1;
            end
            // acknowledge beats a new edge
            if (&cpu_fc && !cpu_asn) begin
                model_irqn = 1'b1;
            end else if (vint && !model_last_vint) begin
                model_irqn = 1'b0;
            end
            model_last_vint = vint;
        end
    end

    initial begin
        logic [2:0] pick;
        seed       = 32'h8d67;
        test_name  = "reset";
        rst        = 1'b1;
        vint       = 1'b0;
        addr       = '0;
        cpu_dout   = '0;
        cpu_dswn   = 2'b11;
        cpu_asn    = 1'b1;
        cpu_fc     = 3'b101;
        cpu_dtackn = 1'b1;
        cpu_bgn    = 1'b1;
        mcu_addr   = '0;
        mcu_dout   = '0;
        mcu_wr     = 1'b0;
        sndmap_rd  = 1'b0;
        dev_br     = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // program all eight regions, control byte first
        test_name = "region decode";
        for (int r = 0; r < `MAPPER_REGIONS; r++) begin
            cpu_write(`MAPPER_REGION_BASE + 2 * r, ctl_tab[r]);
            cpu_write(`MAPPER_REGION_BASE + 2 * r + 1, base_tab[r]);
        end
        // read cycles with half of them on programmed pages and some as acknowledge
        test_name = "wait states";
        for (int i = 0; i < 400; i++) begin
            @(negedge clk);
            addr = 23'($random(seed));
            pick = 3'($random(seed));
            if ($random(seed) & 1) begin
                addr[23:16] = base_tab[pick];
            end
            cpu_fc = (($random(seed) & 7) == 0) ? 3'b111 : 3'b101;
        end

        test_name = "sound latch";
        cpu_write(`MAPPER_SND_LATCH, 8'h5A);
        wait_level("sndmap_obf", 1'b1, 4);
        check_byte("latch data", 8'h5A, sndmap_dout);
        @(negedge clk);
        sndmap_rd = 1'b1;
        @(negedge clk);
        sndmap_rd = 1'b0;
        wait_level("sndmap_obf", 1'b0, 4);

        test_name = "interrupt";
        @(negedge clk);
        vint = 1'b1;
        wait_level("ipl_level4", 1'b1, 4);
        vint = 1'b0;
        // FC all ones without AS is no acknowledge
        @(negedge clk);
        cpu_asn = 1'b1;
        cpu_fc  = 3'b111;
        @(negedge clk);
        check_bit("level 4 kept", 1'b0, cpu_ipln[2]);
        // autovector acknowledge
        cpu_asn = 1'b0;
        @(negedge clk);
        cpu_fc = 3'b101;
        wait_level("ipl_idle", 1'b1, 3);

        // first MCU write only hands over ownership
        test_name = "mcu takeover";
        mcu_write(0, 8'hFF);
        mcu_write(`MAPPER_REGION_BASE + 12, 8'h0C);
        mcu_write(`MAPPER_REGION_BASE + 13, 8'h60);
        cpu_write(`MAPPER_REGION_BASE + 13, 8'h70);
        cpu_write(`MAPPER_SND_LATCH, 8'h33);
        for (int i = 0; i < 40; i++) begin
            @(negedge clk);
            addr = {(i % 2 == 0) ? 8'h60 : 8'h70, 15'($random(seed))};
        end

        test_name = "bus grant";
        @(negedge clk);
        cpu_asn = 1'b1;
        dev_br  = 1'b1;
        wait_level("cpu_brn", 1'b0, 10);
        // grant arrives while the CPU cycle is still open
        cpu_bgn    = 1'b0;
        cpu_dtackn = 1'b0;
        hold_request(3);
        cpu_dtackn = 1'b1;
        cpu_asn    = 1'b0;
        hold_request(3);
        cpu_asn = 1'b1;
        wait_level("cpu_bgackn", 1'b0, 10);
        check_bit("br released", 1'b1, cpu_brn);
        dev_br  = 1'b0;
        cpu_bgn = 1'b1;
        wait_level("cpu_bgackn", 1'b1, 10);
        @(negedge clk);
        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- mapper.f
+incdir+include
src/mapper_pkg.sv
src/mapper_regs.sv
src/region_decode.sv
src/vint_irq.sv
src/bus_arbiter.sv
src/mapper_top.sv
dv/mapper_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= mapper_tb
FILELIST  ?= mapper.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SRCS := $(filter-out +%,$(shell cat $(FILELIST))) $(wildcard include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	@./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "Testbench failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "simulation reported an error, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
